/* Bender.yml */
package:
  name: wb_soc_fabric

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_pkg.sv
      - verilog/wb_if.sv
      - verilog/wb_arbiter2.sv
      - verilog/wb_crossbar.sv
      - verilog/wb_ram.sv
      - verilog/wb_gpio.sv
      - verilog/wb_soc_fabric.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_wb_soc_fabric.sv

/* tb/tb_wb_stim_table.svh */
//////////////////////////////
// Fabric stimulus table
// Bus cycles with expected read data and err
//////////////////////////////
`ifndef TB_WB_STIM_TABLE_SVH
`define TB_WB_STIM_TABLE_SVH

// Row order is master, we, random data flag, address, write data, sel,
// expected read data and expected err
// RAM reads take their expected word from the shadow array instead
task automatic load_stim_table;
    // Random full words, then read-back from both masters
    add_row(1'b1, 1'b1, 1'b1, 32'h0000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h0000_0004, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b1, 1'b1, 32'h0000_0100, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b1, 1'b1, 32'h0000_0FFC, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0FFC, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    // Partial writes
    add_row(1'b1, 1'b1, 1'b0, 32'h0000_0004, 32'hA1B2_C3D4, 4'h5, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b1, 1'b0, 32'h0000_0010, 32'h5566_7788, 4'h8, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b1, 1'b1, 32'h0000_0100, 32'h0000_0000, 4'h2, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b1, 1'b0, 32'h0000_0FFC, 32'h0BAD_F00D, 4'h3, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0FFC, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    // GPIO output and direction registers
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_0000, 32'h0000_00A5, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h1000_0000, 32'h0000_0000, 4'hF, 32'h0000_00A5, 1'b0);
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_0004, 32'hFFFF_FF3C, 4'h1, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h1000_0004, 32'h0000_0000, 4'hF, 32'h0000_003C, 1'b0);
    // Lane above the pins is dropped
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_0000, 32'h0000_FF00, 4'h2, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h1000_0000, 32'h0000_0000, 4'hF, 32'h0000_00A5, 1'b0);
    // Input and spare offsets ignore writes
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_0008, 32'h0000_00FF, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_000C, 32'h0000_00FF, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h1000_0000, 32'h0000_0000, 4'hF, 32'h0000_00A5, 1'b0);
    add_row(1'b1, 1'b0, 1'b0, 32'h1000_0004, 32'h0000_0000, 4'hF, 32'h0000_003C, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h1000_000C, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    // Unmapped addresses, then proof that nothing moved
    add_row(1'b1, 1'b1, 1'b0, 32'h2000_0010, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b1);
    add_row(1'b0, 1'b0, 1'b0, 32'h8000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1);
    add_row(1'b1, 1'b1, 1'b0, 32'h1000_0010, 32'h0000_00FF, 4'hF, 32'h0000_0000, 1'b1);
    add_row(1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(1'b0, 1'b0, 1'b0, 32'h1000_0000, 32'h0000_0000, 4'hF, 32'h0000_00A5, 1'b0);
endtask

`endif

/* tb/tb_wb_soc_fabric.sv */
//////////////////////////////
// SoC bus fabric testbench
// Table-driven cycles from two masters
// RAM shadow, GPIO and contention checks
//////////////////////////////
`timescale 1ns/1ns
`include "soc_consts.svh"

module tb_wb_soc_fabric;
    import soc_pkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 8;
    localparam int MAX_ROWS    = 64;
    localparam int RAM_WORDS   = `RAM_SIZE / 4;

    typedef struct packed {
        logic     mst;
        logic     we;
        logic     rnd;
        wb_addr_t adr;
        wb_data_t wdat;
        wb_sel_t  sel;
        wb_data_t exp_rd;
        logic     exp_err;
    } stim_row_t;

    logic              clk_i;
    logic              arst_n_i;
    wb_addr_t          m0_adr_i;
    wb_data_t          m0_dat_i;
    wb_data_t          m0_dat_o;
    logic              m0_we_i;
    wb_sel_t           m0_sel_i;
    logic              m0_stb_i;
    logic              m0_cyc_i;
    logic              m0_ack_o;
    logic              m0_err_o;
    wb_addr_t          m1_adr_i;
    wb_data_t          m1_dat_i;
    wb_data_t          m1_dat_o;
    logic              m1_we_i;
    wb_sel_t           m1_sel_i;
    logic              m1_stb_i;
    logic              m1_cyc_i;
    logic              m1_ack_o;
    logic              m1_err_o;
    logic [`NGPIO-1:0] gpio_i;
    logic [`NGPIO-1:0] gpio_o;
    logic [`NGPIO-1:0] gpio_oe_o;

    stim_row_t   rows [MAX_ROWS];
    int          n_rows;
    wb_data_t    shadow [RAM_WORDS];
    logic [31:0] lcg_state;
    int          check_errors;
    int          timeout_errors;

    wb_soc_fabric u_dut (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .m0_adr_i  (m0_adr_i),
        .m0_dat_i  (m0_dat_i),
        .m0_dat_o  (m0_dat_o),
        .m0_we_i   (m0_we_i),
        .m0_sel_i  (m0_sel_i),
        .m0_stb_i  (m0_stb_i),
        .m0_cyc_i  (m0_cyc_i),
        .m0_ack_o  (m0_ack_o),
        .m0_err_o  (m0_err_o),
        .m1_adr_i  (m1_adr_i),
        .m1_dat_i  (m1_dat_i),
        .m1_dat_o  (m1_dat_o),
        .m1_we_i   (m1_we_i),
        .m1_sel_i  (m1_sel_i),
        .m1_stb_i  (m1_stb_i),
        .m1_cyc_i  (m1_cyc_i),
        .m1_ack_o  (m1_ack_o),
        .m1_err_o  (m1_err_o),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_ram(wb_addr_t adr);
        return (adr & ~(32'(`RAM_SIZE) - 32'd1)) == `RAM_BASE;
    endfunction

    // Expected word after a byte-lane write
    function automatic wb_data_t merge_lanes(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
        wb_data_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic add_row(input logic mst, input logic we, input logic rnd,
                           input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel,
                           input wb_data_t exp_rd, input logic exp_err);
        rows[n_rows] = {mst, we, rnd, adr, wdat, sel, exp_rd, exp_err};
        n_rows++;
    endtask

    `include "tb_wb_stim_table.svh"

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        check_errors++;
    endtask

    task automatic drive_master(input logic mst, input logic act, input logic we,
                                input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel);
        if (mst == 1'b0) begin
            m0_cyc_i = act;
            m0_stb_i = act;
            m0_we_i  = we;
            m0_adr_i = adr;
            m0_dat_i = wdat;
            m0_sel_i = sel;
        end else begin
            m1_cyc_i = act;
            m1_stb_i = act;
            m1_we_i  = we;
            m1_adr_i = adr;
            m1_dat_i = wdat;
            m1_sel_i = sel;
        end
    endtask

    // One classic cycle, ended by ack or err
    task automatic bus_access(input logic mst, input logic we, input wb_addr_t adr,
                              input wb_data_t wdat, input wb_sel_t sel,
                              output wb_data_t rdata, output logic rsp_err, output logic done);
        int   waited;
        logic ack;
        logic err;
        logic other_rsp;
        waited  = 0;
        done    = 1'b0;
        rdata   = '0;
        rsp_err = 1'b0;
        @(negedge clk_i);
        drive_master(mst, 1'b1, we, adr, wdat, sel);
        while (!done && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
            ack       = mst ? m1_ack_o : m0_ack_o;
            err       = mst ? m1_err_o : m0_err_o;
            other_rsp = mst ? (m0_ack_o | m0_err_o) : (m1_ack_o | m1_err_o);
            if (other_rsp !== 1'b0) begin
                report_mismatch("response seen by idle master", 32'(other_rsp), 32'd0);
            end
            if (ack && err) begin
                report_mismatch("ack and err together", 32'd1, 32'd0);
            end
            if (ack || err) begin
                done    = 1'b1;
                rsp_err = err;
                rdata   = mst ? m1_dat_o : m0_dat_o;
            end
        end
        drive_master(mst, 1'b0, 1'b0, '0, '0, '0);
        if (!done) begin
            $display("Timeout: master %0d got no ack or err for address %h", mst, adr);
            timeout_errors++;
        end
    endtask

    task automatic run_row(input stim_row_t row);
        wb_data_t wdat;
        wb_data_t exp;
        wb_data_t rdata;
        logic     rsp_err;
        logic     done;
        int       idx;
        if (row.rnd) begin
            wdat = lcg_next();
        end else begin
            wdat = row.wdat;
        end
        idx = (row.adr >> 2) % RAM_WORDS;
        bus_access(row.mst, row.we, row.adr, wdat, row.sel, rdata, rsp_err, done);
        if (done) begin
            if (rsp_err !== row.exp_err) begin
                report_mismatch($sformatf("err at %h", row.adr), 32'(rsp_err), 32'(row.exp_err));
            end
            if (row.we && !rsp_err && is_ram(row.adr)) begin
                shadow[idx] = merge_lanes(shadow[idx], wdat, row.sel);
            end
            if (!row.we && !rsp_err) begin
                exp = is_ram(row.adr) ? shadow[idx] : row.exp_rd;
                if (rdata !== exp) begin
                    report_mismatch($sformatf("read data at %h", row.adr), rdata, exp);
                end
            end
        end
    endtask

    task automatic poll_gpio_input(input logic [`NGPIO-1:0] pins);
        wb_data_t rdata;
        logic     rsp_err;
        logic     done;
        logic     seen;
        int       polls;
        seen  = 1'b0;
        polls = 0;
        @(negedge clk_i);
        gpio_i = pins;
        while (!seen && polls < POLL_LIMIT) begin
            bus_access(1'b1, 1'b0, `GPIO_BASE + 32'h8, '0, 4'hF, rdata, rsp_err, done);
            polls++;
            if (done && !rsp_err && rdata === wb_data_t'(pins)) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("Timeout: GPIO input %h never read back at offset 0x8", pins);
            timeout_errors++;
        end
    endtask

    // Master 0 writes, master 1 reads the same word in the same step
    task automatic contend_both;
        wb_addr_t adr;
        wb_data_t wdat;
        wb_data_t m1_rdata;
        int       cyc_cnt;
        int       m0_done_at;
        int       m1_done_at;
        adr        = 32'h0000_0200;
        wdat       = lcg_next();
        m1_rdata   = '0;
        cyc_cnt    = 0;
        m0_done_at = -1;
        m1_done_at = -1;
        @(negedge clk_i);
        drive_master(1'b0, 1'b1, 1'b1, adr, wdat, 4'hF);
        drive_master(1'b1, 1'b1, 1'b0, adr, '0, 4'hF);
        while (m1_done_at < 0 && cyc_cnt < ACK_TIMEOUT) begin
            @(negedge clk_i);
            cyc_cnt++;
            if (m0_err_o || m1_err_o) begin
                report_mismatch("err during contention", 32'd1, 32'd0);
            end
            if (m0_ack_o && m0_done_at < 0) begin
                m0_done_at = cyc_cnt;
                shadow[(adr >> 2) % RAM_WORDS] = wdat;
                drive_master(1'b0, 1'b0, 1'b0, '0, '0, '0);
            end else if (m0_ack_o) begin
                // Master 0 is idle now, any ack here belongs to master 1
                report_mismatch("master 0 ack after its cycle", 32'd1, 32'd0);
            end
            if (m1_ack_o) begin
                m1_done_at = cyc_cnt;
                m1_rdata   = m1_dat_o;
                drive_master(1'b1, 1'b0, 1'b0, '0, '0, '0);
            end
        end
        drive_master(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_master(1'b1, 1'b0, 1'b0, '0, '0, '0);
        if (m0_done_at < 0 || m1_done_at < 0) begin
            $display("Timeout: contending masters did not both finish");
            timeout_errors++;
        end else begin
            if (m1_done_at <= m0_done_at) begin
                report_mismatch("master 1 ack cycle", 32'(m1_done_at), 32'(m0_done_at + 1));
            end
            if (m1_rdata !== shadow[(adr >> 2) % RAM_WORDS]) begin
                report_mismatch("master 1 read after master 0 write", m1_rdata, wdat);
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        check_errors   = 0;
        timeout_errors = 0;
        n_rows         = 0;
        lcg_state      = 32'h1d3f_e724;
        arst_n_i       = 1'b0;
        gpio_i         = '0;
        drive_master(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_master(1'b1, 1'b0, 1'b0, '0, '0, '0);
        repeat (4) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        // Quiet bus and pins out of reset
        if ({m0_ack_o, m0_err_o, m1_ack_o, m1_err_o} !== 4'b0) begin
            report_mismatch("ack and err after reset", 32'({m0_ack_o, m0_err_o,
                            m1_ack_o, m1_err_o}), 32'd0);
        end
        if (gpio_o !== '0) begin
            report_mismatch("gpio_o after reset", 32'(gpio_o), 32'd0);
        end
        if (gpio_oe_o !== '0) begin
            report_mismatch("gpio_oe_o after reset", 32'(gpio_oe_o), 32'd0);
        end

        load_stim_table();
        for (int i = 0; i < n_rows; i++) begin
            run_row(rows[i]);
        end

        // Pins hold the last accepted output and direction writes
        if (gpio_o !== 8'hA5) begin
            report_mismatch("gpio_o pins", 32'(gpio_o), 32'h0000_00A5);
        end
        if (gpio_oe_o !== 8'h3C) begin
            report_mismatch("gpio_oe_o pins", 32'(gpio_oe_o), 32'h0000_003C);
        end

        poll_gpio_input(8'h5A);
        contend_both();

        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+tb
verilog/soc_pkg.sv
verilog/wb_if.sv
verilog/wb_arbiter2.sv
verilog/wb_crossbar.sv
verilog/wb_ram.sv
verilog/wb_gpio.sv
verilog/wb_soc_fabric.sv
tb/tb_wb_soc_fabric.sv

/* verilog/soc_consts.svh */
//////////////////////////////
// SoC bus fabric constants
// Bus widths, memory map, GPIO count
//////////////////////////////
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W  4

// Memory map
`define RAM_BASE  32'h0000_0000
`define RAM_SIZE  4096
`define GPIO_BASE 32'h1000_0000
`define GPIO_SIZE 16

// Aperture masks, derived from the sizes above
`define RAM_MASK  (32'hFFFF_FFFF << $clog2(`RAM_SIZE))
`define GPIO_MASK (32'hFFFF_FFFF << $clog2(`GPIO_SIZE))

// GPIO pins
`define NGPIO 8

`endif

/* verilog/soc_pkg.sv */
//////////////////////////////
// SoC bus types
// Word types, slave select, lane merge
//////////////////////////////
`include "soc_consts.svh"

package soc_pkg;

    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`WB_DATA_W-1:0] wb_data_t;
    typedef logic [`WB_SEL_W-1:0]  wb_sel_t;

    // Decoded target of a bus cycle
    typedef enum logic [1:0] {
        SEL_RAM  = 2'd0,
        SEL_GPIO = 2'd1,
        SEL_NONE = 2'd2
    } slave_sel_e;

    // Replace only the byte lanes enabled in sel
    function automatic wb_data_t apply_sel(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
        wb_data_t res;
        res = old_w;
        for (int i = 0; i < `WB_SEL_W; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* verilog/wb_arbiter2.sv */
//////////////////////////////
// Two-master Wishbone arbiter
// Fixed priority, master 0 first
// Grant held while owner keeps cyc
//////////////////////////////
`timescale 1ns/1ns

module wb_arbiter2 (
    input  logic clk_i,
    input  logic arst_n_i,
    wb_if.slave  m0,
    wb_if.slave  m1,
    wb_if.master s
);

    logic gnt_valid_q;
    logic gnt_idx_q;
    logic gnt_idx;
    logic gnt_active;
    logic own_cyc;

    //////////////////////////////
    // Grant selection
    //////////////////////////////

    // Held grant wins, otherwise idle bus grants in the same cycle
    always_comb begin
        if (gnt_valid_q) begin
            gnt_idx    = gnt_idx_q;
            gnt_active = 1'b1;
        end else if (m0.cyc) begin
            gnt_idx    = 1'b0;
            gnt_active = 1'b1;
        end else begin
            gnt_idx    = 1'b1;
            gnt_active = m1.cyc;
        end
    end

    assign own_cyc = gnt_idx ? m1.cyc : m0.cyc;

    // Owner dropping cyc frees the bus on the next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gnt_valid_q <= 1'b0;
            gnt_idx_q   <= 1'b0;
        end else begin
            gnt_valid_q <= gnt_active && own_cyc;
            if (!gnt_valid_q) begin
                gnt_idx_q <= gnt_idx;
            end
        end
    end

    //////////////////////////////
    // Request and response steering
    //////////////////////////////
    assign s.adr   = gnt_idx ? m1.adr   : m0.adr;
    assign s.dat_w = gnt_idx ? m1.dat_w : m0.dat_w;
    assign s.we    = gnt_idx ? m1.we    : m0.we;
    assign s.sel   = gnt_idx ? m1.sel   : m0.sel;
    assign s.stb   = gnt_active && (gnt_idx ? m1.stb : m0.stb);
    assign s.cyc   = gnt_active && own_cyc;

    // Read data is only meaningful together with ack
    assign m0.dat_r = s.dat_r;
    assign m1.dat_r = s.dat_r;

    assign m0.ack = s.ack && gnt_active && !gnt_idx;
    assign m0.err = s.err && gnt_active && !gnt_idx;
    assign m1.ack = s.ack && gnt_active && gnt_idx;
    assign m1.err = s.err && gnt_active && gnt_idx;

    // Once a cycle is underway the owner keeps the bus
    a_grant_held: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (gnt_active && own_cyc) |=> (gnt_idx == $past(gnt_idx))
    ) else $error("arbiter grant moved during an active cycle");

endmodule

/* verilog/wb_crossbar.sv */
//////////////////////////////
// Wishbone address decoder
// One master to RAM and GPIO
// Unmapped addresses get err
//////////////////////////////
`timescale 1ns/1ns
`include "soc_consts.svh"

module wb_crossbar (
    input  logic clk_i,
    input  logic arst_n_i,
    wb_if.slave  m,
    wb_if.master ram,
    wb_if.master gpio
);
    import soc_pkg::*;

    slave_sel_e target;
    logic       req;

    //////////////////////////////
    // Address decode
    //////////////////////////////
    always_comb begin
        if ((m.adr & `RAM_MASK) == `RAM_BASE) begin
            target = SEL_RAM;
        end else if ((m.adr & `GPIO_MASK) == `GPIO_BASE) begin
            target = SEL_GPIO;
        end else begin
            target = SEL_NONE;
        end
    end

    assign req = m.cyc && m.stb;

    //////////////////////////////
    // Request fan-out
    //////////////////////////////
    assign ram.adr   = m.adr;
    assign ram.dat_w = m.dat_w;
    assign ram.we    = m.we;
    assign ram.sel   = m.sel;
    assign ram.cyc   = m.cyc && (target == SEL_RAM);
    assign ram.stb   = req && (target == SEL_RAM);

    assign gpio.adr   = m.adr;
    assign gpio.dat_w = m.dat_w;
    assign gpio.we    = m.we;
    assign gpio.sel   = m.sel;
    assign gpio.cyc   = m.cyc && (target == SEL_GPIO);
    assign gpio.stb   = req && (target == SEL_GPIO);

    //////////////////////////////
    // Response mux
    //////////////////////////////
    always_comb begin
        case (target)
            SEL_RAM: begin
                m.dat_r = ram.dat_r;
                m.ack   = ram.ack;
                m.err   = ram.err;
            end
            SEL_GPIO: begin
                m.dat_r = gpio.dat_r;
                m.ack   = gpio.ack;
                m.err   = gpio.err;
            end
            default: begin
                // No slave here, answer at once
                m.dat_r = '0;
                m.ack   = 1'b0;
                m.err   = req;
            end
        endcase
    end

    a_ack_err_excl: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(m.ack && m.err)
    ) else $error("ack and err high together");

    // A strobed slave never overlaps an answer still coming from the other
    a_one_slave: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({ram.stb || ram.ack, gpio.stb || gpio.ack})
    ) else $error("more than one slave active");

endmodule

/* verilog/wb_gpio.sv */
//////////////////////////////
// Wishbone GPIO block
// Output, direction, synced input
//////////////////////////////
`timescale 1ns/1ns
`include "soc_consts.svh"

module wb_gpio (
    input  logic              clk_i,
    input  logic              arst_n_i,
    wb_if.slave               bus,
    input  logic [`NGPIO-1:0] gpio_i,
    output logic [`NGPIO-1:0] gpio_o,
    output logic [`NGPIO-1:0] gpio_oe_o
);
    import soc_pkg::*;

    logic [`NGPIO-1:0] out_q;
    logic [`NGPIO-1:0] dir_q;
    logic [`NGPIO-1:0] sync1_q;
    logic [`NGPIO-1:0] sync2_q;
    logic              ack_q;
    logic              access;
    wb_data_t          out_merged;
    wb_data_t          dir_merged;
    wb_data_t          rd_mux;
    wb_data_t          rd_data_q;

    assign access = bus.stb && !ack_q;

    // Current register values with the write lanes applied
    assign out_merged = apply_sel(wb_data_t'(out_q), bus.dat_w, bus.sel);
    assign dir_merged = apply_sel(wb_data_t'(dir_q), bus.dat_w, bus.sel);

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q   <= '0;
            dir_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            ack_q   <= access;
            // Offsets 0x8 and 0xC swallow writes
            if (access && bus.we) begin
                if (bus.adr[3:2] == 2'd0) begin
                    out_q <= out_merged[`NGPIO-1:0];
                end
                if (bus.adr[3:2] == 2'd1) begin
                    dir_q <= dir_merged[`NGPIO-1:0];
                end
            end
        end
    end

    // Read mux, upper bits zero
    always_comb begin
        rd_mux = '0;
        case (bus.adr[3:2])
            2'd0:    rd_mux[`NGPIO-1:0] = out_q;
            2'd1:    rd_mux[`NGPIO-1:0] = dir_q;
            2'd2:    rd_mux[`NGPIO-1:0] = sync2_q;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            rd_data_q <= rd_mux;
        end
    end

    assign bus.dat_r = rd_data_q;
    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;
    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

/* verilog/wb_if.sv */
//////////////////////////////
// Wishbone classic bus link
// One master to one slave
//////////////////////////////
`timescale 1ns/1ns

interface wb_if;
    import soc_pkg::*;

    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     we;
    wb_sel_t  sel;
    logic     stb;
    logic     cyc;
    logic     ack;
    logic     err;

    // Request side
    modport master (
        output adr,
        output dat_w,
        output we,
        output sel,
        output stb,
        output cyc,
        input  dat_r,
        input  ack,
        input  err
    );

    // Response side
    modport slave (
        input  adr,
        input  dat_w,
        input  we,
        input  sel,
        input  stb,
        input  cyc,
        output dat_r,
        output ack,
        output err
    );

endinterface

/* verilog/wb_ram.sv */
//////////////////////////////
// Wishbone single-port RAM
// Word addressed, byte-lane writes
//////////////////////////////
`timescale 1ns/1ns
`include "soc_consts.svh"

module wb_ram (
    input  logic clk_i,
    input  logic arst_n_i,
    wb_if.slave  bus
);
    import soc_pkg::*;

    localparam int RAM_AW    = $clog2(`RAM_SIZE);
    localparam int RAM_WORDS = `RAM_SIZE / 4;

    wb_data_t              mem [RAM_WORDS];
    wb_data_t              rd_data_q;
    logic [RAM_AW-3:0]     word_idx;
    logic                  ack_q;
    logic                  access;

    // Drop the byte offset
    assign word_idx = bus.adr[RAM_AW-1:2];

    // First cycle of a strobe only
    assign access = bus.stb && !ack_q;

    //////////////////////////////
    // Storage
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (bus.we) begin
                mem[word_idx] <= apply_sel(mem[word_idx], bus.dat_w, bus.sel);
            end
            rd_data_q <= mem[word_idx];
        end
    end

    // One ack pulse per new strobe
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus.dat_r = rd_data_q;
    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;

endmodule

/* verilog/wb_soc_fabric.sv */
//////////////////////////////
// SoC bus fabric top level
// Two masters, arbiter, crossbar
// RAM and GPIO slaves
//////////////////////////////
`timescale 1ns/1ns
`include "soc_consts.svh"

module wb_soc_fabric (
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Instruction master
    input  soc_pkg::wb_addr_t m0_adr_i,
    input  soc_pkg::wb_data_t m0_dat_i,
    output soc_pkg::wb_data_t m0_dat_o,
    input  logic              m0_we_i,
    input  soc_pkg::wb_sel_t  m0_sel_i,
    input  logic              m0_stb_i,
    input  logic              m0_cyc_i,
    output logic              m0_ack_o,
    output logic              m0_err_o,

    // Data master
    input  soc_pkg::wb_addr_t m1_adr_i,
    input  soc_pkg::wb_data_t m1_dat_i,
    output soc_pkg::wb_data_t m1_dat_o,
    input  logic              m1_we_i,
    input  soc_pkg::wb_sel_t  m1_sel_i,
    input  logic              m1_stb_i,
    input  logic              m1_cyc_i,
    output logic              m1_ack_o,
    output logic              m1_err_o,

    // GPIO pins
    input  logic [`NGPIO-1:0] gpio_i,
    output logic [`NGPIO-1:0] gpio_o,
    output logic [`NGPIO-1:0] gpio_oe_o
);

    wb_if m0_bus ();
    wb_if m1_bus ();
    wb_if arb_bus ();
    wb_if ram_bus ();
    wb_if gpio_bus ();

    //////////////////////////////
    // Master ports
    //////////////////////////////
    assign m0_bus.adr   = m0_adr_i;
    assign m0_bus.dat_w = m0_dat_i;
    assign m0_bus.we    = m0_we_i;
    assign m0_bus.sel   = m0_sel_i;
    assign m0_bus.stb   = m0_stb_i;
    assign m0_bus.cyc   = m0_cyc_i;
    assign m0_dat_o     = m0_bus.dat_r;
    assign m0_ack_o     = m0_bus.ack;
    assign m0_err_o     = m0_bus.err;

    assign m1_bus.adr   = m1_adr_i;
    assign m1_bus.dat_w = m1_dat_i;
    assign m1_bus.we    = m1_we_i;
    assign m1_bus.sel   = m1_sel_i;
    assign m1_bus.stb   = m1_stb_i;
    assign m1_bus.cyc   = m1_cyc_i;
    assign m1_dat_o     = m1_bus.dat_r;
    assign m1_ack_o     = m1_bus.ack;
    assign m1_err_o     = m1_bus.err;

    //////////////////////////////
    // Fabric
    //////////////////////////////
    wb_arbiter2 u_arbiter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .m0       (m0_bus.slave),
        .m1       (m1_bus.slave),
        .s        (arb_bus.master)
    );

    wb_crossbar u_xbar (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .m        (arb_bus.slave),
        .ram      (ram_bus.master),
        .gpio     (gpio_bus.master)
    );

    wb_ram u_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (ram_bus.slave)
    );

    wb_gpio u_gpio (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .bus       (gpio_bus.slave),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

endmodule
